// ==== tb/blob_stim.txt ====
# Commands: W addr data | R addr expected | E addr | V | L count pixels... | B lines | F
# Addresses and data in hex, counts in decimal, one command per line

# Register values after reset
R 00 00000000
R 04 00000000
R 08 00000000
R 0C 00000000
R 10 00000000

# Control read back, refused writes leave registers alone
W 00 000000F1
R 00 000000F1
E 20
E 10
E 04
R 00 000000F1
R 10 00000000

# Threshold 8, hits at (2,1) (3,2) (4,2) (1,3)
W 00 00000081
V
L 6 000 000 000 000 000 000
L 6 000 000 FFF 777 000 000
L 6 000 F00 0F0 888 FF0 000
L 6 000 0FF 000 000 000 000
L 6 000 000 000 000 000 777
F
R 04 00010001
R 08 00040001
R 0C 00030001
R 10 00000004

# Classifier disabled, empty box each frame
W 00 00000080
V
L 4 FFF FFF FFF FFF
L 4 FFF FFF FFF FFF
F
R 04 00010002
R 08 000003FF
R 0C 000003FF
R 10 00000000
V
L 2 FFF FFF
F
R 04 00010003

# 481 lines, last one lands on y 0
W 00 00000081
V
B 480
L 3 000 FFF 000
F
R 04 00010004
R 08 00010001
R 0C 00000000
R 10 00000001

// ==== project.f ====
src/blob_pkg.sv
src/px_coord_if.sv
src/blob_stats_if.sv
src/coord_tracker.sv
src/luma_classifier.sv
src/blob_accum.sv
src/apb_csr.sv
src/blob_tracker_top.sv
tb/tb_blob_tracker.sv

// ==== tb/tb_blob_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_blob_tracker;
    import blob_pkg::*;

    localparam int poll_limit = 50;

    logic      pclk;
    logic      r2_rst_pclk;
    pixel_t    pix_data;
    logic      pix_valid;
    logic      href;
    logic      vsync;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    integer    fd;
    integer    code;
    integer    seed;
    integer    errors;
    integer    checks;
    logic      timed_out;
    logic      done;
    logic [63:0]   cmd;
    logic [1023:0] linebuf;
    apb_addr_t cmd_addr;
    apb_data_t cmd_data;
    integer    cmd_count;
    // Last value written to the control register
    apb_data_t ctrl_shadow;
    // One camera line as read from the stimulus
    pixel_t    line_px [0:frame_width-1];

    blob_tracker_top dut0 (
        .pclk(pclk),
        .r2_rst_pclk(r2_rst_pclk),
        .pix_data(pix_data),
        .pix_valid(pix_valid),
        .href(href),
        .vsync(vsync),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    always #5 pclk = ~pclk;

    // --------------------------------------------------
    // APB master
    // --------------------------------------------------
    task apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                  output apb_data_t rdata, output logic err);
        // Setup cycle
        @(negedge pclk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        // Access cycle sampled mid low phase
        @(negedge pclk);
        penable = 1'b1;
        #2;
        rdata = prdata;
        err = pslverr;
        if (!pready) begin
            errors = errors + 1;
            $display("mismatch pready at 0x%02h: expected 0x1, got 0x%0h", addr, pready);
        end
        @(negedge pclk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b1, addr, data, rd, err);
        checks = checks + 1;
        if (addr == addr_ctrl) begin
            ctrl_shadow = data;
        end
        if (err) begin
            errors = errors + 1;
            $display("mismatch pslverr at 0x%02h: expected 0x0, got 0x%0h", addr, err);
        end
    endtask

    task check_read(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b0, addr, '0, rd, err);
        checks = checks + 1;
        if (err) begin
            errors = errors + 1;
            $display("mismatch pslverr at 0x%02h: expected 0x0, got 0x%0h", addr, err);
        end
        if (rd !== exp) begin
            errors = errors + 1;
            $display("mismatch prdata at 0x%02h: expected 0x%08h, got 0x%08h", addr, exp, rd);
        end
    endtask

    // Refused write of the inverted control word, so a stray update shows on read back
    task expect_slverr(input apb_addr_t addr);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b1, addr, ~ctrl_shadow, rd, err);
        checks = checks + 1;
        if (!err) begin
            errors = errors + 1;
            $display("no pslverr on write to address 0x%02h", addr);
        end
    endtask

    // --------------------------------------------------
    // Camera stream
    // --------------------------------------------------
    task send_line(input integer n);
        integer i;
        for (i = 0; i < n; i = i + 1) begin
            // Random idle cycle inside the line
            if (($random(seed) & 3) == 0) begin
                @(negedge pclk);
                href = 1'b1;
                pix_valid = 1'b0;
            end
            @(negedge pclk);
            href = 1'b1;
            pix_valid = 1'b1;
            pix_data = line_px[i];
        end
        // Horizontal blanking
        @(negedge pclk);
        href = 1'b0;
        pix_valid = 1'b0;
        pix_data = '0;
        repeat (2) @(negedge pclk);
    endtask

    task start_frame();
        @(negedge pclk);
        vsync = 1'b0;
        // Let the frame start pulse clear the running box
        repeat (4) @(negedge pclk);
    endtask

    task end_frame();
        apb_data_t rd;
        logic      err;
        frame_cnt_t old_cnt;
        frame_cnt_t new_cnt;
        integer     polls;
        apb_xfer(1'b0, addr_status, '0, rd, err);
        old_cnt = rd[15:0];
        new_cnt = old_cnt;
        polls = 0;
        @(negedge pclk);
        vsync = 1'b1;
        while (new_cnt == old_cnt && polls < poll_limit) begin
            apb_xfer(1'b0, addr_status, '0, rd, err);
            new_cnt = rd[15:0];
            polls = polls + 1;
        end
        if (new_cnt == old_cnt) begin
            errors = errors + 1;
            timed_out = 1'b1;
            $display("timeout: frame count stayed at %0d after vsync rose", old_cnt);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        pclk = 1'b0;
        r2_rst_pclk = 1'b0;
        pix_data = '0;
        pix_valid = 1'b0;
        href = 1'b0;
        vsync = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        seed = 32'ha330_7b85;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        done = 1'b0;
        ctrl_shadow = '0;

        repeat (8) @(posedge pclk);
        @(negedge pclk);
        r2_rst_pclk = 1'b1;

        fd = $fopen("tb/blob_stim.txt", "r");
        if (fd == 0) begin
            errors = errors + 1;
            $display("cannot open tb/blob_stim.txt");
            done = 1'b1;
        end
        while (!done && !timed_out) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": code = $fgets(linebuf, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", cmd_addr, cmd_data);
                        write_reg(cmd_addr, cmd_data);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", cmd_addr, cmd_data);
                        check_read(cmd_addr, cmd_data);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h", cmd_addr);
                        expect_slverr(cmd_addr);
                    end
                    "V": start_frame();
                    "L": begin
                        code = $fscanf(fd, "%d", cmd_count);
                        for (int i = 0; i < cmd_count; i++) begin
                            code = $fscanf(fd, "%h", line_px[i]);
                        end
                        send_line(cmd_count);
                    end
                    "B": begin
                        code = $fscanf(fd, "%d", cmd_count);
                        line_px[0] = '0;
                        line_px[1] = '0;
                        repeat (cmd_count) send_line(2);
                    end
                    "F": end_frame();
                    default: begin
                        errors = errors + 1;
                        $display("unknown stimulus command %0s", cmd);
                        done = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/blob_tracker_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module blob_tracker_top (
    input  logic                pclk,
    input  logic                r2_rst_pclk,
    // Camera stream
    input  blob_pkg::pixel_t    pix_data,
    input  logic                pix_valid,
    input  logic                href,
    input  logic                vsync,
    // APB slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  blob_pkg::apb_addr_t paddr,
    input  blob_pkg::apb_data_t pwdata,
    output blob_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr
);
    import blob_pkg::*;

    logic  mask, mask_valid;
    logic  enable;
    luma_t threshold;

    px_coord_if   coord_bus ();
    blob_stats_if stats_bus ();

    // --------------------------------------------------
    // Pixel path, position and mask side by side
    // --------------------------------------------------
    coord_tracker coord_trk (
        .pclk(pclk),
        .r2_rst_pclk(r2_rst_pclk),
        .href(href),
        .vsync(vsync),
        .pix_valid(pix_valid),
        .coord(coord_bus.src)
    );

    luma_classifier luma_cls (
        .pclk(pclk),
        .r2_rst_pclk(r2_rst_pclk),
        .pix_data(pix_data),
        .pix_valid(pix_valid),
        .enable(enable),
        .threshold(threshold),
        .mask(mask),
        .mask_valid(mask_valid)
    );

    // Box and area per frame
    blob_accum blob_acc (
        .pclk(pclk),
        .r2_rst_pclk(r2_rst_pclk),
        .coord(coord_bus.dst),
        .mask(mask),
        .mask_valid(mask_valid),
        .stats(stats_bus.src)
    );

    // --------------------------------------------------
    // Register block
    // --------------------------------------------------
    apb_csr csr (
        .pclk(pclk),
        .r2_rst_pclk(r2_rst_pclk),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .stats(stats_bus.dst),
        .enable(enable),
        .threshold(threshold)
    );

endmodule

`default_nettype wire

// ==== src/apb_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_csr (
    input  logic                pclk,
    input  logic                r2_rst_pclk,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  blob_pkg::apb_addr_t paddr,
    input  blob_pkg::apb_data_t pwdata,
    output blob_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr,
    blob_stats_if.dst           stats,
    output logic                enable,
    output blob_pkg::luma_t     threshold
);
    import blob_pkg::*;

    logic      ctrl_en;
    luma_t     ctrl_thr;
    logic      mapped;
    logic      access;
    apb_data_t rd_data;

    // Zero-wait slave
    assign pready = 1'b1;
    assign access = psel && penable;

    // --------------------------------------------------
    // Address decode and read mux
    // --------------------------------------------------
    always_comb begin
        mapped = 1'b1;
        rd_data = '0;
        case (paddr)
            addr_ctrl: begin
                rd_data[ctrl_en_bit] = ctrl_en;
                rd_data[ctrl_thr_lsb +: 4] = ctrl_thr;
            end
            addr_status: rd_data = {15'd0, stats.stats_valid, stats.frame_count};
            addr_bbox_x: begin
                rd_data[coord_w-1:0] = stats.min_x;
                rd_data[bbox_max_lsb +: coord_w] = stats.max_x;
            end
            addr_bbox_y: begin
                rd_data[coord_w-1:0] = stats.min_y;
                rd_data[bbox_max_lsb +: coord_w] = stats.max_y;
            end
            addr_area: rd_data = {13'd0, stats.area};
            default: mapped = 1'b0;
        endcase
    end

    assign prdata = rd_data;
    // Unmapped, or a write to a read-only word
    assign pslverr = access && (!mapped || (pwrite && paddr != addr_ctrl));

    // Control write at the access edge
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            ctrl_en <= 1'b0;
            ctrl_thr <= '0;
        end else if (access && pwrite && paddr == addr_ctrl) begin
            ctrl_en <= pwdata[ctrl_en_bit];
            ctrl_thr <= pwdata[ctrl_thr_lsb +: 4];
        end
    end

    assign enable = ctrl_en;
    assign threshold = ctrl_thr;

    // Access phase only right after a setup phase
    assert property (@(posedge pclk) disable iff (!r2_rst_pclk)
        penable |-> psel && $past(psel && !penable));

endmodule

`default_nettype wire

// ==== src/blob_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module blob_accum (
    input  logic      pclk,
    input  logic      r2_rst_pclk,
    px_coord_if.dst   coord,
    input  logic      mask,
    input  logic      mask_valid,
    blob_stats_if.src stats
);
    import blob_pkg::*;

    coord_t run_min_x, run_max_x;
    coord_t run_min_y, run_max_y;
    area_t  run_area;
    logic   hit;

    // Mask pixel with a valid position
    assign hit = coord.valid && mask_valid && mask;

    // --------------------------------------------------
    // Running box and area
    // --------------------------------------------------
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            run_min_x <= coord_empty_min;
            run_min_y <= coord_empty_min;
            run_max_x <= '0;
            run_max_y <= '0;
            run_area <= '0;
        end else if (coord.frame_start) begin
            // Empty box for the new frame
            run_min_x <= coord_empty_min;
            run_min_y <= coord_empty_min;
            run_max_x <= '0;
            run_max_y <= '0;
            run_area <= '0;
        end else if (hit) begin
            if (coord.x < run_min_x) run_min_x <= coord.x;
            if (coord.x > run_max_x) run_max_x <= coord.x;
            if (coord.y < run_min_y) run_min_y <= coord.y;
            if (coord.y > run_max_y) run_max_y <= coord.y;
            run_area <= run_area + area_t'(1);
        end
    end

    // --------------------------------------------------
    // Frame end latch
    // --------------------------------------------------
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            stats.min_x <= '0;
            stats.max_x <= '0;
            stats.min_y <= '0;
            stats.max_y <= '0;
            stats.area <= '0;
            stats.frame_count <= '0;
            stats.stats_valid <= 1'b0;
        end else if (coord.frame_end) begin
            stats.min_x <= run_min_x;
            stats.max_x <= run_max_x;
            stats.min_y <= run_min_y;
            stats.max_y <= run_max_y;
            stats.area <= run_area;
            stats.frame_count <= stats.frame_count + frame_cnt_t'(1);
            stats.stats_valid <= 1'b1;
        end
    end

    // A populated box never comes out inverted
    assert property (@(posedge pclk) disable iff (!r2_rst_pclk)
        (stats.stats_valid && stats.area != '0) |->
        (stats.min_x <= stats.max_x && stats.min_y <= stats.max_y));

endmodule

`default_nettype wire

// ==== src/luma_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module luma_classifier (
    input  logic             pclk,
    input  logic             r2_rst_pclk,
    input  blob_pkg::pixel_t pix_data,
    input  logic             pix_valid,
    input  logic             enable,
    input  blob_pkg::luma_t  threshold,
    output logic             mask,
    output logic             mask_valid
);
    import blob_pkg::*;

    // r + 2g + b tops out at 60
    logic [5:0] luma_sum;
    luma_t      luma;

    // --------------------------------------------------
    // Luma estimate
    // --------------------------------------------------
    assign luma_sum = {2'b00, pix_data[11:8]}
                    + {1'b0, pix_data[7:4], 1'b0}
                    + {2'b00, pix_data[3:0]};

    // Divide by 4 and truncate
    assign luma = luma_sum[5:2];

    // Registered with the tracker stage so both paths line up
    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            mask <= 1'b0;
            mask_valid <= 1'b0;
        end else begin
            mask <= enable && (luma >= threshold);
            mask_valid <= pix_valid;
        end
    end

endmodule

`default_nettype wire

// ==== src/coord_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module coord_tracker (
    input  logic   pclk,
    input  logic   r2_rst_pclk,
    input  logic   href,
    input  logic   vsync,
    input  logic   pix_valid,
    px_coord_if.src coord
);
    import blob_pkg::*;

    logic   href_d1;
    logic   vsync_d1, vsync_d2;
    logic   line_end;
    coord_t x_cnt;
    coord_t y_cnt;

    // Line ends on href falling
    assign line_end = href_d1 && !href;

    always_ff @(posedge pclk or negedge r2_rst_pclk) begin
        if (!r2_rst_pclk) begin
            href_d1 <= 1'b0;
            // Idle high, so release never looks like a frame end
            vsync_d1 <= 1'b1;
            vsync_d2 <= 1'b1;
            x_cnt <= '0;
            y_cnt <= '0;
            coord.x <= '0;
            coord.y <= '0;
            coord.valid <= 1'b0;
            coord.frame_start <= 1'b0;
            coord.frame_end <= 1'b0;
        end else begin
            href_d1 <= href;
            vsync_d1 <= vsync;
            vsync_d2 <= vsync_d1;

            // Current position goes out with the pixel
            coord.x <= x_cnt;
            coord.y <= y_cnt;
            coord.valid <= pix_valid && href;

            // Frame markers, one cycle after the sampled edge
            coord.frame_start <= vsync_d2 && !vsync_d1;
            coord.frame_end <= !vsync_d2 && vsync_d1;

            // Column count
            if (line_end) begin
                x_cnt <= '0;
            end else if (pix_valid && href) begin
                x_cnt <= x_cnt + coord_t'(1);
            end

            // Line count, frame start has priority
            if (vsync_d2 && !vsync_d1) begin
                y_cnt <= '0;
            end else if (line_end) begin
                if (y_cnt == coord_t'(frame_height - 1))
                    y_cnt <= '0;
                else
                    y_cnt <= y_cnt + coord_t'(1);
            end
        end
    end

    // More pixels per line than the frame is wide
    assert property (@(posedge pclk) disable iff (!r2_rst_pclk)
        coord.valid |-> coord.x < coord_t'(frame_width));

endmodule

`default_nettype wire

// ==== src/blob_stats_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Latched results of the last completed frame
interface blob_stats_if;
    import blob_pkg::*;

    coord_t     min_x;
    coord_t     max_x;
    coord_t     min_y;
    coord_t     max_y;
    area_t      area;
    frame_cnt_t frame_count;
    // Set once the first frame has ended
    logic       stats_valid;

    modport src (output min_x, max_x, min_y, max_y, area, frame_count, stats_valid);

    modport dst (input min_x, max_x, min_y, max_y, area, frame_count, stats_valid);

endinterface

`default_nettype wire

// ==== src/px_coord_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pixel position stream out of the coordinate tracker
interface px_coord_if;
    import blob_pkg::*;

    coord_t x;
    coord_t y;
    // Pixel present on this cycle
    logic   valid;
    // One-cycle frame markers
    logic   frame_start;
    logic   frame_end;

    // Tracker side
    modport src (output x, y, valid, frame_start, frame_end);

    // Accumulator side
    modport dst (input x, y, valid, frame_start, frame_end);

endinterface

`default_nettype wire

// ==== src/blob_pkg.sv ====
`default_nettype none

package blob_pkg;

    // --------------------------------------------------
    // Frame geometry
    // --------------------------------------------------
    localparam int frame_width  = 640;
    localparam int frame_height = 480;
    localparam int coord_w      = 10;

    // Column or line number
    typedef logic [coord_w-1:0] coord_t;
    // RGB444 with red on top and blue at the bottom
    typedef logic [11:0] pixel_t;
    // Luma and threshold on the same 4-bit scale
    typedef logic [3:0]  luma_t;
    // Mask pixel count, wide enough for a full frame
    typedef logic [18:0] area_t;
    typedef logic [15:0] frame_cnt_t;

    // Min reported when a frame has no mask pixels
    localparam coord_t coord_empty_min = 10'h3FF;

    // --------------------------------------------------
    // APB register map
    // --------------------------------------------------
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Control register holds enable and threshold
    localparam apb_addr_t addr_ctrl   = 8'h00;
    // Frame count low half, valid flag at bit 16
    localparam apb_addr_t addr_status = 8'h04;
    // Both bbox words keep min low and max high
    localparam apb_addr_t addr_bbox_x = 8'h08;
    localparam apb_addr_t addr_bbox_y = 8'h0C;
    localparam apb_addr_t addr_area   = 8'h10;

    // Control field positions
    localparam int ctrl_en_bit  = 0;
    localparam int ctrl_thr_lsb = 4;
    // Upper field of a bbox word
    localparam int bbox_max_lsb = 16;

endpackage

`default_nettype wire
